// File: filelist.f
+incdir+verilog
verilog/mipsIsaPkg.sv
verilog/mipsCtrlPkg.sv
verilog/controlDecoder.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/loadStoreUnit.sv
verilog/programSequencer.sv
verilog/mipsCore.sv
verif/retireChecker.sv
verif/mipsCoreTb.sv

// File: Makefile
TOP = mipsCoreTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: verif/mipsCoreTb.sv
`timescale 1ns/10ps
`include "mipsConfig.svh"

module mipsCoreTb;

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    localparam int ProgWords   = 64;
    localparam int ResetCycles = 5;
    localparam int AluCycles   = 300;
    localparam int MemCycles   = 300;
    localparam int FlowCycles  = 300;
    localparam int ZeroCycles  = 200;
    localparam int CycleLimit  = 2 * (AluCycles + MemCycles + FlowCycles + ZeroCycles
                                      + 4 * ResetCycles);
    localparam logic [31:0] LfsrSeed = 32'd80451;
    localparam logic [31:0] LfsrTaps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    retireT      retire;
    logic [31:0] prog [0:ProgWords-1]; // Instruction memory image
    logic [31:0] lfsr;
    int          cycleCount;
    int          errTotal;
    int          checkTotal;
    int          testsPassed;
    int          testsFailed;

    mipsCore i_mipsCore (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    retireChecker i_retireChecker (
        .clk        (clk),
        .rstN       (rstN),
        .pc         (pc),
        .instr      (instr),
        .retire     (retire),
        .errCount   (errTotal),
        .checkCount (checkTotal)
    );

    always #4 clk = ~clk; // 8 ns period

    // Combinational fetch, pc has settled 1 ns after the edge
    always @(posedge clk) begin
        #1;
        instr = prog[pc[7:2]];
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LfsrTaps : 32'd0);
        end
        return r;
    endfunction

    function automatic logic [5:0] pickFunct();
        case (int'(randBits(3)) % 5)
            0:       return fnAdd;
            1:       return fnSub;
            2:       return fnAnd;
            3:       return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    function automatic bit isDefined(input logic [5:0] op);
        return op inside {opRtype, opJ, opBeq, opAddi, opLw, opSw};
    endfunction

    // Random instruction for word idx, mix depends on the test
    function automatic logic [31:0] genWord(input int testId, input int idx);
        logic [1:0]  sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] memOff;
        logic [4:0]  rsSmall;
        logic [4:0]  rtSmall;
        logic [5:0]  op;
        int          target;
        sel     = 2'(randBits(2));
        rs      = 5'(randBits(5));
        rt      = 5'(randBits(5));
        rd      = 5'(randBits(5));
        imm     = 16'(randBits(16));
        memOff  = {8'd0, 6'(randBits(6)), 2'b00}; // Word offset below 256
        rsSmall = {3'd0, 2'(randBits(2))};        // r0..r3, equal values are common
        rtSmall = {3'd0, 2'(randBits(2))};
        target  = int'(randBits(6));              // Any word of the program
        op      = 6'(randBits(6));
        if (isDefined(op)) begin
            op = op + 6'd1; // Neighbor of a defined opcode is undefined
        end
        case (testId)
            0: return (sel == 2'd3) ? {opAddi, rs, rt, imm}
                                    : {opRtype, rs, rt, rd, 5'd0, pickFunct()};
            1: case (sel)
                0:       return {opAddi, rs, rt, imm};
                1:       return {opSw, 5'd0, rt, memOff};
                default: return {opLw, 5'd0, rt, memOff};
            endcase
            2: case (sel)
                0:       return {opAddi, rsSmall, rtSmall, 16'(randBits(2))};
                3:       return {opJ, 20'd0, 6'(target)};
                default: return {opBeq, rsSmall, rtSmall, 16'(target - idx - 1)};
            endcase
            default: case (sel)
                0:       return {op, 26'(randBits(26))};
                1:       return rd[0] ? {opAddi, rs, 5'd0, imm}
                                      : {opRtype, rs, rt, 5'd0, 5'd0, pickFunct()};
                2:       return {opRtype, 5'd0, rt, rd, 5'd0, pickFunct()}; // Reads r0
                default: return {opAddi, 5'd0, rt, imm};
            endcase
        endcase
    endfunction

    task automatic runTest(input int testId, input string name, input int cycles);
        int errBefore;
        errBefore = errTotal;
        @(posedge clk);
        #1;
        rstN = 1'b0;
        for (int i = 0; i < ProgWords - 1; i++) begin
            prog[i] = genWord(testId, i);
        end
        prog[ProgWords-1] = {opJ, 26'd0}; // Wrap back to word 0
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (cycles) @(posedge clk);
        @(negedge clk); // Let the checker see the last record
        #1;
        if (errTotal == errBefore) begin
            testsPassed++;
            $display("Test %0d %s: ok after %0d cycles", testId, name, cycles);
        end else begin
            testsFailed++;
            $display("Test %0d %s: FAILED with %0d mismatches", testId, name,
                     errTotal - errBefore);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        instr       = 32'd0;
        lfsr        = LfsrSeed;
        cycleCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        for (int i = 0; i < ProgWords; i++) begin
            prog[i] = 32'd0;
        end
        runTest(0, "aluOps", AluCycles);
        runTest(1, "loadStore", MemCycles);
        runTest(2, "branchJump", FlowCycles);
        runTest(3, "zeroRegUndef", ZeroCycles);
        $display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d",
                 testsPassed, testsFailed, checkTotal, errTotal);
        if (testsFailed == 0 && errTotal == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/retireChecker.sv
`timescale 1ns/10ps
`include "mipsConfig.svh"

module retireChecker (
    input  logic                clk,
    input  logic                rstN,
    input  logic [31:0]         pc,         // DUT fetch address
    input  logic [31:0]         instr,      // Word the testbench fetched
    input  mipsCtrlPkg::retireT retire,     // DUT commit record
    output int                  errCount,   // Mismatches seen so far
    output int                  checkCount  // Field compares done so far
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    localparam int AddrW = $clog2(`MIPS_DMEM_WORDS);

    logic [31:0] regs [0:31];                // Model register file, r0 never written
    logic [31:0] mem [0:`MIPS_DMEM_WORDS-1]; // Model data memory
    logic [31:0] modelPc;
    retireT      expRec;                     // Record due in the next cycle
    bit          pending;                    // A commit happened last edge

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            errCount++;
            $display("[FAIL] %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
        end
    endtask

    // Executes the fetched word on the model and builds its expected record
    task automatic stepModel();
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] pc4;
        logic [31:0] val;
        logic        wr;
        a      = regs[instr[25:21]];
        b      = regs[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        addr   = a + simm;
        pc4    = modelPc + 32'd4;
        dest   = instr[20:16]; // rt unless R-type
        val    = 32'd0;
        wr     = 1'b0;
        expRec = '0;
        expRec.valid = 1'b1;
        expRec.pc    = modelPc;
        modelPc      = pc4;
        case (instr[31:26])
            opRtype: begin
                dest = instr[15:11];
                wr   = 1'b1;
                case (instr[5:0])
                    fnAdd:   val = a + b;
                    fnSub:   val = a - b;
                    fnAnd:   val = a & b;
                    fnOr:    val = a | b;
                    fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0; // Unknown funct is a no-op
                endcase
            end
            opAddi: begin
                val = a + simm;
                wr  = 1'b1;
            end
            opLw: begin
                val = mem[addr[AddrW+1:2]];
                wr  = 1'b1;
            end
            opSw: begin
                expRec.memWe   = 1'b1;
                expRec.memAddr = {addr[31:2], 2'b00};
                expRec.memData = b;
                mem[addr[AddrW+1:2]] = b;
            end
            opBeq:   if (a == b) modelPc = pc4 + {simm[29:0], 2'b00};
            opJ:     modelPc = {pc4[31:28], instr[25:0], 2'b00};
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin // r0 writes vanish
            expRec.regWe  = 1'b1;
            expRec.wrReg  = dest;
            expRec.wrData = val;
            regs[dest]    = val;
        end
    endtask

    // Mid-cycle sampling, all DUT outputs and instr are settled here
    always @(negedge clk) begin
        if (!rstN) begin
            checkField("pc during reset", `MIPS_RESET_PC, pc);
            checkField("retire.valid during reset", 32'd0, 32'(retire.valid));
            for (int i = 0; i < 32; i++) begin
                regs[i] = 32'd0;
            end
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                mem[i] = 32'd0;
            end
            modelPc = `MIPS_RESET_PC;
            pending = 1'b0;
        end else begin
            checkField("pc", modelPc, pc);
            if (pending && !retire.valid) begin
                errCount++;
                $display("At time %0t the retire record is missing its valid strobe", $time);
            end else if (pending) begin
                checkField("retire.pc", expRec.pc, retire.pc);
                checkField("retire.regWe", 32'(expRec.regWe), 32'(retire.regWe));
                checkField("retire.wrReg", 32'(expRec.wrReg), 32'(retire.wrReg));
                checkField("retire.wrData", expRec.wrData, retire.wrData);
                checkField("retire.memWe", 32'(expRec.memWe), 32'(retire.memWe));
                checkField("retire.memAddr", expRec.memAddr, retire.memAddr);
                checkField("retire.memData", expRec.memData, retire.memData);
            end else begin
                checkField("retire.valid after reset", 32'd0, 32'(retire.valid)); // No commit yet
            end
            stepModel();
            pending = 1'b1;
        end
    end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic                clk,
    input  logic                rstN,
    input  logic [31:0]         instr,  // Word at pc, same cycle
    output logic [31:0]         pc,     // Fetch address
    output mipsCtrlPkg::retireT retire  // One record per commit, next cycle
);

    import mipsCtrlPkg::*;

    ctrlT        ctrl;      // Decoded control, shared by all blocks
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] wbData;    // Load data or ALU result
    logic [4:0]  wrReg;     // rd or rt
    logic        regWe;     // Write enable after r0 filter

    controlDecoder i_controlDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    registerFile i_registerFile (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .rs     (instr[25:21]), // rs field
        .rt     (instr[20:16]), // rt field
        .rd     (instr[15:11]), // rd field
        .wbData (wbData),
        .rsData (rsData),
        .rtData (rtData),
        .wrReg  (wrReg),
        .regWe  (regWe)
    );

    aluUnit i_aluUnit (
        .ctrl      (ctrl),
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (instr[15:0]), // I-type immediate
        .aluResult (aluResult),
        .zero      (zero)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .rtData    (rtData),
        .wbData    (wbData)
    );

    programSequencer i_programSequencer (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .instr     (instr),
        .zero      (zero),
        .regWe     (regWe),
        .wrReg     (wrReg),
        .wbData    (wbData),
        .aluResult (aluResult),
        .rtData    (rtData),
        .pc        (pc),
        .retire    (retire)
    );

endmodule

// File: verilog/programSequencer.sv
`timescale 1ns/10ps
`include "mipsConfig.svh"

module programSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  mipsCtrlPkg::ctrlT   ctrl,      // branch, jump, memWrite used
    input  logic [31:0]         instr,     // Immediate and jump index source
    input  logic                zero,      // ALU zero, beq condition
    input  logic                regWe,     // Qualified register write
    input  logic [4:0]          wrReg,
    input  logic [31:0]         wbData,
    input  logic [31:0]         aluResult, // Store address
    input  logic [31:0]         rtData,    // Store data
    output logic [31:0]         pc,        // Fetch address
    output mipsCtrlPkg::retireT retire     // Record of last commit
);

    import mipsCtrlPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    retireT      retireNext; // Record of the instruction now committing

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00}; // Word offset
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};            // Region kept
    assign nextPc       = ctrl.jump ? jumpTarget :
                          (ctrl.branch && zero) ? branchTarget : pcPlus4;

    always_comb begin
        retireNext         = '0;
        retireNext.valid   = 1'b1;
        retireNext.pc      = pc;
        retireNext.regWe   = regWe;
        retireNext.wrReg   = regWe ? wrReg : 5'd0;   // Fields cleared when unused
        retireNext.wrData  = regWe ? wbData : 32'd0;
        retireNext.memWe   = ctrl.memWrite;
        retireNext.memAddr = ctrl.memWrite ? {aluResult[31:2], 2'b00} : 32'd0;
        retireNext.memData = ctrl.memWrite ? rtData : 32'd0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `MIPS_RESET_PC;
            retire <= '0; // No commit seen yet
        end else begin
            pc     <= nextPc;
            retire <= retireNext;
        end
    end

    // Fetch address stays word aligned across every redirect
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC lost word alignment: %h", pc);

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/10ps
`include "mipsConfig.svh"

module loadStoreUnit (
    input  logic              clk,
    input  logic              rstN,
    input  mipsCtrlPkg::ctrlT ctrl,      // memRead, memWrite, memToReg used
    input  logic [31:0]       aluResult, // Byte address or ALU value
    input  logic [31:0]       rtData,    // Store data
    output logic [31:0]       wbData     // Value for register write-back
);

    localparam int AddrW = $clog2(`MIPS_DMEM_WORDS);

    logic [31:0]      mem [0:`MIPS_DMEM_WORDS-1];
    logic [AddrW-1:0] wordAddr; // Byte address with low two bits dropped
    logic [31:0]      loadData;

    assign wordAddr = aluResult[AddrW+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.memWrite) begin
            mem[wordAddr] <= rtData; // Store lands at the commit edge
        end
    end

    assign loadData = ctrl.memRead ? mem[wordAddr] : 32'd0; // Same-cycle read
    assign wbData   = ctrl.memToReg ? loadData : aluResult;

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/10ps
`include "mipsConfig.svh"

module registerFile (
    input  logic              clk,
    input  logic              rstN,
    input  mipsCtrlPkg::ctrlT ctrl,   // regWrite and regDst used here
    input  logic [4:0]        rs,     // Read port A index
    input  logic [4:0]        rt,     // Read port B index
    input  logic [4:0]        rd,     // R-type destination
    input  logic [31:0]       wbData, // Write-back value
    output logic [31:0]       rsData,
    output logic [31:0]       rtData,
    output logic [4:0]        wrReg,  // Selected destination
    output logic              regWe   // Qualified write enable
);

    logic [31:0] regs [1:`MIPS_REG_COUNT-1]; // r0 has no storage

    assign wrReg = ctrl.regDst ? rd : rt;
    assign regWe = ctrl.regWrite && (wrReg != 5'd0); // Writes to r0 are dropped

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[wrReg] <= wbData;
        end
    end

    assign rsData = (rs == 5'd0) ? 32'd0 : regs[rs]; // r0 reads as zero
    assign rtData = (rt == 5'd0) ? 32'd0 : regs[rt];

    // Committed write value is held by its register after the edge
    assert property (@(posedge clk) disable iff (!rstN)
        (regWe && rstN) |=> (regs[$past(wrReg)] == $past(wbData)))
        else $error("Register write did not land in storage");

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  mipsCtrlPkg::ctrlT ctrl,      // aluOp and aluSrcImm used here
    input  logic [31:0]       rsData,    // First operand
    input  logic [31:0]       rtData,    // Register second operand
    input  logic [15:0]       imm,       // Raw immediate field
    output logic [31:0]       aluResult, // Operation result
    output logic              zero       // Result is zero, for beq
);

    import mipsIsaPkg::*;

    logic [31:0] immExt; // Sign-extended immediate
    logic [31:0] opB;    // Selected second operand

    assign immExt = {{16{imm[15]}}, imm};
    assign opB    = ctrl.aluSrcImm ? immExt : rtData; // I-type uses immediate

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = rsData - opB;
            aluAnd:  aluResult = rsData & opB;
            aluOr:   aluResult = rsData | opB;
            aluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(opB)}; // Signed compare
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

endmodule

// File: verilog/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
    input  logic [31:0]       instr, // Fetched instruction word
    output mipsCtrlPkg::ctrlT ctrl   // Decoded control bundle
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    opcodeE opcode; // Primary opcode field
    functE  funct;  // R-type function field

    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);

    always_comb begin
        ctrl = '0; // Inactive default so unknown encodings retire as no-op
        case (opcode)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1; // Result goes to rd
                case (funct)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl = '0; // Undefined funct drops the write
                endcase
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1; // Address is rs + offset
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluOp     = aluAdd;
            end
            opSw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1; // rt is the store data
                ctrl.aluOp     = aluAdd;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub; // Zero flag means equal
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: verilog/mipsCtrlPkg.sv
package mipsCtrlPkg;

    // Decoded control for one instruction
    typedef struct packed {
        logic               regWrite;  // Write back to register file
        logic               regDst;    // Destination is rd, else rt
        logic               aluSrcImm; // Second ALU operand is immediate
        logic               memRead;   // Load from data memory
        logic               memWrite;  // Store to data memory
        logic               memToReg;  // Write-back takes load data
        logic               branch;    // beq, taken when ALU zero
        logic               jump;      // Unconditional jump
        mipsIsaPkg::aluOpE  aluOp;     // ALU operation
    } ctrlT;

    // Record of one committed instruction, registered
    typedef struct packed {
        logic        valid;   // One-cycle strobe per commit
        logic [31:0] pc;      // Address of committed instruction
        logic        regWe;   // Register file was written
        logic [4:0]  wrReg;   // Destination, 0 when regWe low
        logic [31:0] wrData;  // Write-back value, 0 when regWe low
        logic        memWe;   // Data memory was written
        logic [31:0] memAddr; // Word-aligned store address
        logic [31:0] memData; // Store data, 0 when memWe low
    } retireT;

endpackage

// File: verilog/mipsIsaPkg.sv
package mipsIsaPkg;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'h00, // Register format, operation in funct
        opJ     = 6'h02, // Absolute jump within 256 MB region
        opBeq   = 6'h04, // Branch if rs equals rt
        opAddi  = 6'h08, // Add sign-extended immediate
        opLw    = 6'h23, // Load word
        opSw    = 6'h2B  // Store word
    } opcodeE;

    // R-type function code, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'h20, // rd = rs + rt
        fnSub = 6'h22, // rd = rs - rt
        fnAnd = 6'h24, // rd = rs & rt
        fnOr  = 6'h25, // rd = rs | rt
        fnSlt = 6'h2A  // rd = signed rs < rt
    } functE;

    // Internal ALU operation select
    typedef enum logic [2:0] {
        aluAdd = 3'd0, // Also used for address generation
        aluSub = 3'd1, // Also used for beq compare
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4  // Signed compare, result is 0 or 1
    } aluOpE;

endpackage

// File: verilog/mipsConfig.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Core build-time parameters

// Data memory depth in 32-bit words
// 64 words means ALU result bits 7:2 form the word address
`define MIPS_DMEM_WORDS 64

// First fetch address once reset is released
`define MIPS_RESET_PC 32'h0000_0000

// Architectural register count, r0 included
`define MIPS_REG_COUNT 32

`endif
